// File: hw/board_pkg.sv
package board_pkg;

    // board inputs
    // push buttons, one interrupt source each
    localparam int num_buttons = 4;

    // slide switches, only used to gate the heartbeat
    localparam int num_switches = 4;

    // LEDs driven from the register file
    // led[0] is the heartbeat and is not counted here
    localparam int num_gpio = 3;

    // register port geometry
    localparam int addr_width = 2;
    localparam int data_width = 8;

    // register map
    // pending, write one to clear
    localparam logic [addr_width-1:0] reg_pending = 2'd0;

    // interrupt enable mask
    localparam logic [addr_width-1:0] reg_enable = 2'd1;

    // gpio outputs, drives led[3:1]
    localparam logic [addr_width-1:0] reg_gpio = 2'd2;

    // address 3 is unmapped and reads as zero

endpackage

// File: hw/button_conditioner.sv
`timescale 1ns/1ns

module button_conditioner #(
    parameter int btn_stable_cycles = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [board_pkg::num_buttons-1:0] btn,
    output logic [board_pkg::num_buttons-1:0] btn_rise
);

    import board_pkg::*;

    // one low sample then stable high, oldest sample in the msb
    localparam logic [btn_stable_cycles-1:0] rise_pattern =
        {1'b0, {(btn_stable_cycles - 1){1'b1}}};

    // sample history per button
    logic [num_buttons-1:0][btn_stable_cycles-1:0] history;

    always_ff @(posedge clk) begin
        if (rst) begin
            history  <= '0;
            btn_rise <= '0;
        end else begin
            for (int i = 0; i < num_buttons; i++) begin
                // shift the raw button in at the lsb
                history[i] <= {history[i][btn_stable_cycles-2:0], btn[i]};
                // pattern only matches once per press,
                // the low sample shifts out on the next edge
                btn_rise[i] <= (history[i] == rise_pattern);
            end
        end
    end

    // pulse is single cycle per bit, even with a held button
    assert property (@(posedge clk) disable iff (rst)
        (btn_rise & $past(btn_rise)) == '0)
    else $error("btn_rise held high for two cycles: %b", btn_rise);

endmodule

// File: hw/heartbeat_led.sv
`timescale 1ns/1ns

module heartbeat_led #(
    parameter int heartbeat_bits = 25
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [board_pkg::num_switches-1:0] switch,
    output logic                           led_heartbeat
);

    import board_pkg::*;

    // two stage switch synchronizer
    logic [num_switches-1:0] switch_meta;
    logic [num_switches-1:0] switch_sync;

    // free running counter, msb is the blink
    logic [heartbeat_bits-1:0] counter;

    // async board inputs, no reset on the sync flops
    always_ff @(posedge clk) begin
        switch_meta <= switch;
        switch_sync <= switch_meta;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // heartbeat only visible while any switch is on
    always_ff @(posedge clk) begin
        if (rst) begin
            led_heartbeat <= 1'b0;
        end else begin
            led_heartbeat <= counter[heartbeat_bits-1] & (|switch_sync);
        end
    end

endmodule

// File: hw/platform_regs.sv
`timescale 1ns/1ns

module platform_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [board_pkg::num_buttons-1:0] btn_rise,
    input  logic                             reg_wr,
    input  logic                             reg_rd,
    input  logic [board_pkg::addr_width-1:0] reg_addr,
    input  logic [board_pkg::data_width-1:0] reg_wdata,
    output logic [board_pkg::data_width-1:0] reg_rdata,
    output logic                             irq,
    output logic [board_pkg::num_gpio-1:0]    gpio
);

    import board_pkg::*;

    // interrupt state
    logic [num_buttons-1:0] pending;
    logic [num_buttons-1:0] enable;

    // write decode
    logic wr_pending;
    logic wr_enable;
    logic wr_gpio;

    // bits cleared by a pending write this cycle
    logic [num_buttons-1:0] clear_mask;

    // read mux output, zero extended
    logic [data_width-1:0] rd_word;

    assign wr_pending = reg_wr && (reg_addr == reg_pending);
    assign wr_enable  = reg_wr && (reg_addr == reg_enable);
    assign wr_gpio    = reg_wr && (reg_addr == reg_gpio);

    assign clear_mask = wr_pending ? reg_wdata[num_buttons-1:0] : '0;

    // pending latch
    // set wins over a clear on the same bit
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clear_mask) | btn_rise;
        end
    end

    // enable mask and gpio, plain write registers
    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= '0;
            gpio   <= '0;
        end else begin
            if (wr_enable) begin
                enable <= reg_wdata[num_buttons-1:0];
            end
            if (wr_gpio) begin
                gpio <= reg_wdata[num_gpio-1:0];
            end
        end
    end

    // registered interrupt line
    // one cycle behind pending and enable
    always_ff @(posedge clk) begin
        if (rst) begin
            irq <= 1'b0;
        end else begin
            irq <= |(pending & enable);
        end
    end

    // read select
    always_comb begin
        rd_word = '0;
        case (reg_addr)
            reg_pending: rd_word[num_buttons-1:0] = pending;
            reg_enable:  rd_word[num_buttons-1:0] = enable;
            reg_gpio:    rd_word[num_gpio-1:0]    = gpio;
            // unmapped reads as zero
            default:     rd_word = '0;
        endcase
    end

    // read data lands one cycle after the strobe, then holds
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_word;
        end
    end

    // core side never issues both strobes at once
    assert property (@(posedge clk) disable iff (rst)
        !(reg_wr && reg_rd))
    else $error("reg_wr and reg_rd high together");

    // masked sources must not reach irq
    assert property (@(posedge clk) disable iff (rst)
        (enable == '0) |=> !irq)
    else $error("irq high after a cycle with all sources masked");

endmodule

// File: hw/board_top.sv
`timescale 1ns/1ns

module board_top #(
    parameter int btn_stable_cycles = 16,
    parameter int heartbeat_bits    = 25
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [board_pkg::num_buttons-1:0]  btn,
    input  logic [board_pkg::num_switches-1:0] switch,
    input  logic                              reg_wr,
    input  logic                              reg_rd,
    input  logic [board_pkg::addr_width-1:0]  reg_addr,
    input  logic [board_pkg::data_width-1:0]  reg_wdata,
    output logic [board_pkg::data_width-1:0]  reg_rdata,
    output logic                              irq,
    output logic [board_pkg::num_gpio:0]       led
);

    import board_pkg::*;

    // debounced press pulses, one per button
    logic [num_buttons-1:0] btn_rise;

    // register driven leds
    logic [num_gpio-1:0] gpio;

    // heartbeat blink
    logic led_heartbeat;

    button_conditioner #(
        .btn_stable_cycles(btn_stable_cycles)
    ) u_button_conditioner (
        .clk,
        .rst,
        .btn,
        .btn_rise
    );

    heartbeat_led #(
        .heartbeat_bits(heartbeat_bits)
    ) u_heartbeat_led (
        .clk,
        .rst,
        .switch,
        .led_heartbeat
    );

    platform_regs u_platform_regs (
        .clk,
        .rst,
        .btn_rise,
        .reg_wr,
        .reg_rd,
        .reg_addr,
        .reg_wdata,
        .reg_rdata,
        .irq,
        .gpio
    );

    // led 0 blinks, the rest come from the gpio register
    assign led = {gpio, led_heartbeat};

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);

    // free running clock, 8 ns period
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset held over the first rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tests/tb_board_top.sv
`timescale 1ns/1ns

module tb_board_top;

    import board_pkg::*;

    // short filter and heartbeat so the run stays small
    localparam int stable_n = 6;
    localparam int hb_bits = 5;
    localparam int hb_period = 1 << hb_bits;
    // under 800 cycles of tests, with a wide margin
    localparam int timeout_cycles = 3000;

    logic                    clk;
    logic                    rst;
    logic [num_buttons-1:0]  btn;
    logic [num_switches-1:0] switch;
    logic                    reg_wr;
    logic                    reg_rd;
    logic [addr_width-1:0]   reg_addr;
    logic [data_width-1:0]   reg_wdata;
    logic [data_width-1:0]   reg_rdata;
    logic                    irq;
    logic [num_gpio:0]       led;

    string test_name = "reset";
    int cycle_count = 0;
    logic [16:0] lfsr_state = 17'd78320;

    // reference model state
    int run_m [num_buttons];
    logic [num_buttons-1:0]  rise_m;
    logic [num_buttons-1:0]  pend_m;
    logic [num_buttons-1:0]  en_m;
    logic [num_buttons-1:0]  clr_m;
    logic [num_gpio-1:0]     gpio_m;
    logic                    irq_m;
    logic [data_width-1:0]   rdata_m;
    logic [num_switches-1:0] sync1_m;
    logic [num_switches-1:0] sync2_m;
    int                      cnt_m;
    logic                    led0_m;

    tb_clock u_clock (
        .clk,
        .rst
    );

    board_top #(
        .btn_stable_cycles(stable_n),
        .heartbeat_bits(hb_bits)
    ) UUT (
        .clk,
        .rst,
        .btn,
        .switch,
        .reg_wr,
        .reg_rd,
        .reg_addr,
        .reg_wdata,
        .reg_rdata,
        .irq,
        .led
    );

    // x^17 + x^14 + 1, maximal length
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %s %s: expected %0h actual %0h", test_name, what, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "check on %s did not hold", what);
    endtask

    // what a read of addr should return, zero extended
    function automatic logic [data_width-1:0] expected_read(input logic [addr_width-1:0] addr);
        logic [data_width-1:0] word;
        word = '0;
        if (addr == reg_pending) begin
            word[num_buttons-1:0] = pend_m;
        end else if (addr == reg_enable) begin
            word[num_buttons-1:0] = en_m;
        end else if (addr == reg_gpio) begin
            word[num_gpio-1:0] = gpio_m;
        end
        return word;
    endfunction

    // write one clears pending bits
    always_comb begin
        clr_m = '0;
        if (reg_wr && reg_addr == reg_pending) begin
            clr_m = reg_wdata[num_buttons-1:0];
        end
    end

    // cycle model
    // debounce as a run length of high samples, reset counts as low
    always @(posedge clk) begin
        sync1_m <= switch;
        sync2_m <= sync1_m;
        if (rst) begin
            for (int i = 0; i < num_buttons; i++) begin
                run_m[i] <= 0;
            end
            rise_m  <= '0;
            pend_m  <= '0;
            en_m    <= '0;
            gpio_m  <= '0;
            irq_m   <= 1'b0;
            rdata_m <= '0;
            cnt_m   <= 0;
            led0_m  <= 1'b0;
        end else begin
            for (int i = 0; i < num_buttons; i++) begin
                if (!btn[i]) begin
                    run_m[i] <= 0;
                end else if (run_m[i] < stable_n) begin
                    run_m[i] <= run_m[i] + 1;
                end
                // exactly stable_n-1 highs after a low
                rise_m[i] <= (run_m[i] == stable_n - 1);
            end
            // a press beats a clear on the same bit
            pend_m <= (pend_m & ~clr_m) | rise_m;
            if (reg_wr && reg_addr == reg_enable) begin
                en_m <= reg_wdata[num_buttons-1:0];
            end
            if (reg_wr && reg_addr == reg_gpio) begin
                gpio_m <= reg_wdata[num_gpio-1:0];
            end
            irq_m <= (pend_m & en_m) != '0;
            if (reg_rd) begin
                rdata_m <= expected_read(reg_addr);
            end
            cnt_m <= (cnt_m + 1) % hb_period;
            // top bit is set in the upper half of the count
            led0_m <= (cnt_m >= hb_period / 2) && (sync2_m != '0);
        end
    end

    // outputs against the model every cycle
    assert property (@(posedge clk) disable iff (rst) irq == irq_m)
    else report_mismatch("irq", 32'($sampled(irq_m)), 32'($sampled(irq)));

    assert property (@(posedge clk) disable iff (rst) reg_rdata == rdata_m)
    else report_mismatch("reg_rdata", 32'($sampled(rdata_m)), 32'($sampled(reg_rdata)));

    assert property (@(posedge clk) disable iff (rst) led[num_gpio:1] == gpio_m)
    else report_mismatch("led gpio", 32'($sampled(gpio_m)), 32'($sampled(led[num_gpio:1])));

    assert property (@(posedge clk) disable iff (rst) led[0] == led0_m)
    else report_mismatch("led heartbeat", 32'($sampled(led0_m)), 32'($sampled(led[0])));

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: %s still running after %0d cycles", test_name, cycle_count);
            $display("TEST FAILED");
            $fatal(1, "run did not finish in time");
        end
    end

    // all stimulus tasks start and end on a falling edge
    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic reg_write(input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input logic [addr_width-1:0] addr);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        @(negedge clk);
    endtask

    task automatic press(input int b, input int high_cycles);
        btn[b] = 1'b1;
        idle(high_cycles);
        btn[b] = 1'b0;
        idle(stable_n);
    endtask

    // a few short bounces, then one real press held past its pulse
    task automatic bounce_and_press(input int b);
        int bounces;
        int len;
        int hold;
        take_bits(2, bounces);
        for (int k = 0; k <= bounces; k++) begin
            take_bits(2, len);
            btn[b] = 1'b1;
            idle(len + 1);
            btn[b] = 1'b0;
            take_bits(2, len);
            idle(len + 1);
        end
        take_bits(4, hold);
        btn[b] = 1'b1;
        idle(stable_n + 2);
        reg_read(reg_pending);
        // clear while still held so a second pulse would show on irq
        reg_write(reg_pending, 8'hff);
        idle(hold + 1);
        btn[b] = 1'b0;
        idle(stable_n);
    endtask

    initial begin
        int value;
        int hold;
        btn       = '0;
        switch    = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        wait (rst == 1'b0);
        @(negedge clk);

        test_name = "reset";
        for (int a = 0; a < 4; a++) begin
            reg_read(a[addr_width-1:0]);
        end

        test_name = "debounce";
        // all sources enabled so any stray pending bit shows on irq
        reg_write(reg_enable, 8'h0f);
        for (int b = 0; b < num_buttons; b++) begin
            bounce_and_press(b);
            reg_read(reg_pending);
        end
        reg_write(reg_pending, 8'hff);
        reg_read(reg_pending);
        reg_write(reg_enable, 8'h00);

        test_name = "irq_mask";
        press(1, stable_n + 2);
        assert (irq == 1'b0) else report_mismatch("masked irq", 32'd0, 32'(irq));
        reg_read(reg_pending);
        reg_write(reg_enable, 8'h02);
        idle(1);
        assert (irq == 1'b1) else report_mismatch("enabled irq", 32'd1, 32'(irq));
        // clear lands on the same edge as a new press
        btn[1] = 1'b1;
        idle(stable_n);
        reg_write(reg_pending, 8'h02);
        btn[1] = 1'b0;
        idle(1);
        assert (irq == 1'b1) else report_mismatch("set over clear", 32'd1, 32'(irq));
        reg_read(reg_pending);
        reg_write(reg_pending, 8'h02);
        idle(1);
        assert (irq == 1'b0) else report_mismatch("cleared irq", 32'd0, 32'(irq));
        reg_write(reg_enable, 8'h00);

        test_name = "gpio";
        for (int g = 0; g < 8; g++) begin
            take_bits(8, value);
            reg_write(reg_gpio, value[7:0]);
            reg_read(reg_gpio);
        end

        test_name = "heartbeat";
        switch = '0;
        idle(2 * hb_period);
        for (int p = 0; p < 5; p++) begin
            take_bits(num_switches, value);
            switch = value[num_switches-1:0];
            take_bits(5, hold);
            idle(hb_period + hold);
        end
        switch = '0;
        idle(hb_period);

        test_name = "read_data";
        reg_write(reg_enable, 8'hf5);
        reg_write(2'd3, 8'hff);
        for (int a = 0; a < 4; a++) begin
            reg_read(a[addr_width-1:0]);
        end
        reg_write(reg_enable, 8'h00);
        reg_read(reg_enable);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: sources.f
hw/board_pkg.sv
hw/button_conditioner.sv
hw/heartbeat_led.sv
hw/platform_regs.sv
hw/board_top.sv
tests/tb_clock.sv
tests/tb_board_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the board testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_board_top -o tb_board_top

status=0
./obj_dir/tb_board_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "TEST PASSED" sim.log
